// File: rtl/csr_params.svh
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// data path and pc width
`define CSR_XLEN        32

// field widths
`define CSR_NUM_W       14
`define CSR_ECODE_W     6
`define CSR_ESUB_W      9
`define CSR_HWI_W       8

// crmd resets with DA set, PLV 0 and IE 0
`define CSR_CRMD_W      9
`define CSR_CRMD_RST    9'd8

// bit 10 of the interrupt status vector is reserved
`define CSR_IS_W        13
`define CSR_LIE_MASK    13'h1bff

// eentry alignment
`define CSR_ENTRY_LSB   6

`endif

// File: rtl/csr_op_pkg.sv
`default_nettype none

`include "csr_params.svh"

package csr_op_pkg;

    typedef enum logic [2:0] {
        OP_NONE    = 3'd0,
        OP_CSRRD   = 3'd1,
        OP_CSRWR   = 3'd2,
        OP_CSRXCHG = 3'd3,
        OP_ERTN    = 3'd4,
        OP_EXCP    = 3'd5
    } csr_op_e;

    typedef enum logic [`CSR_ECODE_W-1:0] {
        INT  = 6'h00,
        PIL  = 6'h01,
        PIS  = 6'h02,
        PIF  = 6'h03,
        PME  = 6'h04,
        PPI  = 6'h07,
        ADE  = 6'h08,
        ALE  = 6'h09,
        SYS  = 6'h0b,
        BRK  = 6'h0c,
        INE  = 6'h0d,
        TLBR = 6'h3f
    } ecode_e;

    // fetch address fault
    localparam logic [`CSR_ESUB_W-1:0] ADEF = 9'd0;

endpackage

`default_nettype wire

// File: rtl/csr_map_pkg.sv
`default_nettype none

`include "csr_params.svh"

package csr_map_pkg;

    typedef enum logic [`CSR_NUM_W-1:0] {
        CRMD   = 14'h000,
        PRMD   = 14'h001,
        ECFG   = 14'h004,
        ESTAT  = 14'h005,
        ERA    = 14'h006,
        BADV   = 14'h007,
        EENTRY = 14'h00c,
        SAVE0  = 14'h030,
        SAVE1  = 14'h031,
        SAVE2  = 14'h032,
        SAVE3  = 14'h033,
        TCFG   = 14'h041,
        TVAL   = 14'h042,
        TICLR  = 14'h044
    } csr_num_e;

endpackage

`default_nettype wire

// File: rtl/csr_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_params.svh"

module csr_decode
    import csr_op_pkg::*;
    import csr_map_pkg::*;
(
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   req_valid,
    input  csr_op_e                req_op,
    input  logic [`CSR_NUM_W-1:0]  req_csr_num,
    input  logic [`CSR_XLEN-1:0]   req_wdata,
    input  logic [`CSR_XLEN-1:0]   req_mask,
    input  logic [`CSR_XLEN-1:0]   req_pc,
    input  ecode_e                 req_ecode,
    input  logic [`CSR_ESUB_W-1:0] req_esubcode,
    input  logic [`CSR_XLEN-1:0]   req_badv,
    input  logic [`CSR_XLEN-1:0]   rd_value,
    input  logic                   irq_pending,
    input  logic                   redirect_valid,
    output logic                   req_ready,
    output csr_num_e               rd_num,
    output logic                   accept,
    output csr_op_e                d_op,
    output csr_num_e               d_num,
    output logic [`CSR_XLEN-1:0]   d_wdata,
    output logic [`CSR_XLEN-1:0]   d_old,
    output logic [`CSR_XLEN-1:0]   d_pc,
    output ecode_e                 d_ecode,
    output logic [`CSR_ESUB_W-1:0] d_esub,
    output logic [`CSR_XLEN-1:0]   d_badv
);

    logic [`CSR_XLEN-1:0] eff_mask;

    // fetch is redirected, hold off until the stage drains
    assign req_ready = ~redirect_valid;
    assign accept    = req_valid & req_ready;

    assign rd_num = csr_num_e'(req_csr_num);
    assign d_num  = rd_num;
    assign d_old  = rd_value;
    assign d_pc   = req_pc;

    // csrwr writes the whole register
    assign eff_mask = (req_op == OP_CSRWR) ? '1 : req_mask;
    assign d_wdata  = (req_wdata & eff_mask) | (rd_value & ~eff_mask);

    // a pending interrupt wins over whatever was requested
    always_comb
    begin
        d_op    = req_op;
        d_ecode = req_ecode;
        d_esub  = req_esubcode;
        if (irq_pending)
        begin
            d_op    = OP_EXCP;
            d_ecode = INT;
            d_esub  = '0;
        end
    end

    assign d_badv = (d_ecode == ADE && d_esub == ADEF) ? req_pc : req_badv;

    a_no_empty_accept: assert property (
        @(posedge clk) disable iff (!rstn)
        accept |-> req_op != OP_NONE
    );

endmodule

`default_nettype wire

// File: rtl/csr_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_params.svh"

module csr_stage
    import csr_op_pkg::*;
    import csr_map_pkg::*;
(
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   accept,
    input  csr_op_e                d_op,
    input  csr_num_e               d_num,
    input  logic [`CSR_XLEN-1:0]   d_wdata,
    input  logic [`CSR_XLEN-1:0]   d_old,
    input  logic [`CSR_XLEN-1:0]   d_pc,
    input  ecode_e                 d_ecode,
    input  logic [`CSR_ESUB_W-1:0] d_esub,
    input  logic [`CSR_XLEN-1:0]   d_badv,
    input  logic [`CSR_XLEN-1:0]   eentry,
    input  logic [`CSR_XLEN-1:0]   era,
    output logic                   commit_valid,
    output csr_op_e                commit_op,
    output csr_num_e               commit_num,
    output logic [`CSR_XLEN-1:0]   commit_wdata,
    output logic [`CSR_XLEN-1:0]   commit_pc,
    output ecode_e                 commit_ecode,
    output logic [`CSR_ESUB_W-1:0] commit_esub,
    output logic [`CSR_XLEN-1:0]   commit_badv,
    output logic [`CSR_XLEN-1:0]   rdata,
    output logic                   redirect_valid,
    output logic [`CSR_XLEN-1:0]   redirect_pc,
    output logic                   excp_flush,
    output logic                   ertn_flush
);

    logic                 valid_q;
    logic [`CSR_XLEN-1:0] old_q;

    always_ff @(posedge clk)
    begin
        if (!rstn)
            valid_q <= 1'b0;
        else
            valid_q <= accept;
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            commit_op    <= d_op;
            commit_num   <= d_num;
            commit_wdata <= d_wdata;
            old_q        <= d_old;
            commit_pc    <= d_pc;
            commit_ecode <= d_ecode;
            commit_esub  <= d_esub;
            commit_badv  <= d_badv;
        end
    end

    assign commit_valid = valid_q;

    // only the csr instructions return the old value
    assign rdata = (valid_q && (commit_op == OP_CSRRD || commit_op == OP_CSRWR ||
                    commit_op == OP_CSRXCHG)) ? old_q : '0;

    assign redirect_valid = valid_q && commit_op != OP_CSRRD;
    assign excp_flush     = valid_q && commit_op == OP_EXCP;
    assign ertn_flush     = valid_q && commit_op == OP_ERTN;

    always_comb
    begin
        case (commit_op)
            OP_ERTN: redirect_pc = era;
            OP_EXCP: redirect_pc = eentry;
            default: redirect_pc = commit_pc + 32'd4;
        endcase
    end

    a_redirect_gap: assert property (
        @(posedge clk) disable iff (!rstn)
        redirect_valid |=> !redirect_valid
    );

endmodule

`default_nettype wire

// File: rtl/csr_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_params.svh"

module csr_file
    import csr_op_pkg::*;
    import csr_map_pkg::*;
(
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   commit_valid,
    input  csr_op_e                commit_op,
    input  csr_num_e               commit_num,
    input  logic [`CSR_XLEN-1:0]   commit_wdata,
    input  logic [`CSR_XLEN-1:0]   commit_pc,
    input  ecode_e                 commit_ecode,
    input  logic [`CSR_ESUB_W-1:0] commit_esub,
    input  logic [`CSR_XLEN-1:0]   commit_badv,
    input  csr_num_e               rd_num,
    input  logic [`CSR_HWI_W-1:0]  hw_int,
    input  logic [`CSR_XLEN-1:0]   tcfg,
    input  logic [`CSR_XLEN-1:0]   tval,
    input  logic                   timer_irq,
    output logic [`CSR_XLEN-1:0]   rd_value,
    output logic                   irq_pending,
    output logic [`CSR_XLEN-1:0]   eentry,
    output logic [`CSR_XLEN-1:0]   era,
    output logic [1:0]             crmd_plv,
    output logic                   crmd_ie,
    output logic                   tcfg_we,
    output logic                   ticlr_we,
    output logic [`CSR_XLEN-1:0]   tcfg_wdata
);

    logic [`CSR_CRMD_W-1:0]            crmd;
    logic [2:0]                        prmd;
    logic [`CSR_IS_W-1:0]              ecfg_lie;
    logic [1:0]                        estat_is;
    ecode_e                            estat_ecode;
    logic [`CSR_ESUB_W-1:0]            estat_esub;
    logic [`CSR_XLEN-1:0]              badv;
    logic [`CSR_XLEN-1:`CSR_ENTRY_LSB] eentry_q;
    logic [`CSR_XLEN-1:0]              save0, save1, save2, save3;
    logic [`CSR_IS_W-1:0]              is_vec;
    logic                              wr;
    logic                              badv_load;

    assign is_vec      = {1'b0, timer_irq, 1'b0, hw_int, estat_is};
    assign irq_pending = (|(is_vec & ecfg_lie)) & crmd[2];

    assign eentry   = {eentry_q, {`CSR_ENTRY_LSB{1'b0}}};
    assign crmd_plv = crmd[1:0];
    assign crmd_ie  = crmd[2];

    assign wr         = commit_valid && (commit_op == OP_CSRWR || commit_op == OP_CSRXCHG);
    assign tcfg_we    = wr && commit_num == TCFG;
    assign ticlr_we   = wr && commit_num == TICLR && commit_wdata[0];
    assign tcfg_wdata = commit_wdata;

    // address-related faults record the bad address
    assign badv_load = commit_ecode inside {ALE, PIL, PIS, PIF, PME, PPI, TLBR} ||
                       (commit_ecode == ADE && commit_esub == ADEF);

    always_comb
    begin
        case (rd_num)
            CRMD:    rd_value = {23'b0, crmd};
            PRMD:    rd_value = {29'b0, prmd};
            ECFG:    rd_value = {19'b0, ecfg_lie};
            ESTAT:   rd_value = {1'b0, estat_esub, estat_ecode, 3'b0, is_vec};
            ERA:     rd_value = era;
            BADV:    rd_value = badv;
            EENTRY:  rd_value = eentry;
            SAVE0:   rd_value = save0;
            SAVE1:   rd_value = save1;
            SAVE2:   rd_value = save2;
            SAVE3:   rd_value = save3;
            TCFG:    rd_value = tcfg;
            TVAL:    rd_value = tval;
            default: rd_value = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd        <= `CSR_CRMD_RST;
            prmd        <= '0;
            ecfg_lie    <= '0;
            estat_is    <= '0;
            estat_ecode <= INT;
            estat_esub  <= '0;
            era         <= '0;
            badv        <= '0;
            eentry_q    <= '0;
            save0       <= '0;
            save1       <= '0;
            save2       <= '0;
            save3       <= '0;
        end
        else if (commit_valid && commit_op == OP_EXCP)
        begin
            prmd        <= crmd[2:0];
            crmd[2:0]   <= 3'b000;
            era         <= commit_pc;
            estat_ecode <= commit_ecode;
            estat_esub  <= commit_esub;
            if (badv_load)
                badv <= commit_badv;
        end
        else if (commit_valid && commit_op == OP_ERTN)
            crmd[2:0] <= prmd;
        else if (wr)
        begin
            case (commit_num)
                CRMD:    crmd     <= commit_wdata[`CSR_CRMD_W-1:0];
                PRMD:    prmd     <= commit_wdata[2:0];
                ECFG:    ecfg_lie <= commit_wdata[`CSR_IS_W-1:0] & `CSR_LIE_MASK;
                ESTAT:   estat_is <= commit_wdata[1:0];
                ERA:     era      <= commit_wdata;
                BADV:    badv     <= commit_wdata;
                EENTRY:  eentry_q <= commit_wdata[`CSR_XLEN-1:`CSR_ENTRY_LSB];
                SAVE0:   save0    <= commit_wdata;
                SAVE1:   save1    <= commit_wdata;
                SAVE2:   save2    <= commit_wdata;
                SAVE3:   save3    <= commit_wdata;
                default: ;
            endcase
        end
    end

    a_commit_has_op: assert property (
        @(posedge clk) disable iff (!rstn)
        commit_valid |-> commit_op != OP_NONE
    );

endmodule

`default_nettype wire

// File: rtl/csr_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_params.svh"

module csr_timer (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 tcfg_we,
    input  logic [`CSR_XLEN-1:0] tcfg_wdata,
    input  logic                 ticlr_we,
    output logic [`CSR_XLEN-1:0] tcfg,
    output logic [`CSR_XLEN-1:0] tval,
    output logic                 timer_irq
);

    logic expire;

    // bit 0 enable, bit 1 periodic
    assign expire = tcfg[0] && !tcfg_we && tval == '0;

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tcfg <= '0;
            tval <= '0;
        end
        else if (tcfg_we)
        begin
            tcfg <= tcfg_wdata;
            tval <= {tcfg_wdata[`CSR_XLEN-1:2], 2'b00};
        end
        else if (expire)
            tval <= tcfg[1] ? {tcfg[`CSR_XLEN-1:2], 2'b00} : '1;
        else if (tcfg[0] && tval != '1)
            tval <= tval - 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
            timer_irq <= 1'b0;
        else if (ticlr_we)
            timer_irq <= 1'b0;
        else if (expire)
            timer_irq <= 1'b1;
    end

endmodule

`default_nettype wire

// File: rtl/csr_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_params.svh"

module csr_top
    import csr_op_pkg::*;
    import csr_map_pkg::*;
(
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   req_valid,
    input  csr_op_e                req_op,
    input  logic [`CSR_NUM_W-1:0]  req_csr_num,
    input  logic [`CSR_XLEN-1:0]   req_wdata,
    input  logic [`CSR_XLEN-1:0]   req_mask,
    input  logic [`CSR_XLEN-1:0]   req_pc,
    input  ecode_e                 req_ecode,
    input  logic [`CSR_ESUB_W-1:0] req_esubcode,
    input  logic [`CSR_XLEN-1:0]   req_badv,
    input  logic [`CSR_HWI_W-1:0]  hw_int,
    output logic                   req_ready,
    output logic [`CSR_XLEN-1:0]   rdata,
    output logic                   redirect_valid,
    output logic [`CSR_XLEN-1:0]   redirect_pc,
    output logic                   excp_flush,
    output logic                   ertn_flush,
    output logic [1:0]             crmd_plv,
    output logic                   crmd_ie
);

    csr_num_e               rd_num;
    logic [`CSR_XLEN-1:0]   rd_value;
    logic                   irq_pending;
    logic                   accept;
    csr_op_e                d_op;
    csr_num_e               d_num;
    logic [`CSR_XLEN-1:0]   d_wdata, d_old, d_pc, d_badv;
    ecode_e                 d_ecode;
    logic [`CSR_ESUB_W-1:0] d_esub;
    logic                   commit_valid;
    csr_op_e                commit_op;
    csr_num_e               commit_num;
    logic [`CSR_XLEN-1:0]   commit_wdata, commit_pc, commit_badv;
    ecode_e                 commit_ecode;
    logic [`CSR_ESUB_W-1:0] commit_esub;
    logic [`CSR_XLEN-1:0]   eentry, era;
    logic                   tcfg_we, ticlr_we, timer_irq;
    logic [`CSR_XLEN-1:0]   tcfg_wdata, tcfg, tval;

    csr_decode i_csr_decode (.*);

    csr_stage i_csr_stage (.*);

    csr_file i_csr_file (.*);

    csr_timer i_csr_timer (
        .clk        (clk),
        .rstn       (rstn),
        .tcfg_we    (tcfg_we),
        .tcfg_wdata (tcfg_wdata),
        .ticlr_we   (ticlr_we),
        .tcfg       (tcfg),
        .tval       (tval),
        .timer_irq  (timer_irq)
    );

endmodule

`default_nettype wire

// File: dv/csr_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_params.svh"

module csr_tb
    import csr_op_pkg::*;
    import csr_map_pkg::*;
();

    localparam int WAIT_LIMIT = 64;

    logic                   clk;
    logic                   rstn;
    logic                   req_valid;
    csr_op_e                req_op;
    logic [`CSR_NUM_W-1:0]  req_csr_num;
    logic [`CSR_XLEN-1:0]   req_wdata;
    logic [`CSR_XLEN-1:0]   req_mask;
    logic [`CSR_XLEN-1:0]   req_pc;
    ecode_e                 req_ecode;
    logic [`CSR_ESUB_W-1:0] req_esubcode;
    logic [`CSR_XLEN-1:0]   req_badv;
    logic [`CSR_HWI_W-1:0]  hw_int;
    logic                   req_ready;
    logic [`CSR_XLEN-1:0]   rdata;
    logic                   redirect_valid;
    logic [`CSR_XLEN-1:0]   redirect_pc;
    logic                   excp_flush;
    logic                   ertn_flush;
    logic [1:0]             crmd_plv;
    logic                   crmd_ie;

    // reference model of the architectural state
    logic [8:0]  m_crmd;
    logic [2:0]  m_prmd;
    logic [12:0] m_ecfg;
    logic [1:0]  m_is;
    logic [5:0]  m_ecode;
    logic [8:0]  m_esub;
    logic [31:0] m_era;
    logic [31:0] m_badv;
    logic [31:0] m_eentry;
    logic [31:0] m_save [4];
    logic [31:0] m_tcfg;
    logic        m_timer_irq;
    logic [31:0] m_tval_lo;
    logic [31:0] m_tval_hi;

    logic [31:0] seed;
    logic [31:0] pc_ctr;
    string       test_name;
    int          checks;
    int          errors;
    int          test_checks;
    int          test_errors;
    int          tests_run;

    // one entry per accepted request, checked in the following cycle
    logic [31:0] exp_lo_q [$];
    logic [31:0] exp_hi_q [$];
    logic [31:0] exp_pc_q [$];
    logic        exp_redir_q [$];
    logic        exp_excp_q [$];
    logic        exp_ertn_q [$];

    csr_top i_csr_top (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [12:0] model_is();
        return {1'b0, m_timer_irq, 1'b0, hw_int, m_is};
    endfunction

    function automatic logic [31:0] model_read(input logic [13:0] num);
        case (num)
            CRMD:    return {23'b0, m_crmd};
            PRMD:    return {29'b0, m_prmd};
            ECFG:    return {19'b0, m_ecfg};
            ESTAT:   return {1'b0, m_esub, m_ecode, 3'b0, model_is()};
            ERA:     return m_era;
            BADV:    return m_badv;
            EENTRY:  return m_eentry;
            SAVE0:   return m_save[0];
            SAVE1:   return m_save[1];
            SAVE2:   return m_save[2];
            SAVE3:   return m_save[3];
            TCFG:    return m_tcfg;
            default: return '0;
        endcase
    endfunction

    function automatic void model_write(input logic [13:0] num, input logic [31:0] v);
        case (num)
            CRMD:   m_crmd = v[8:0];
            PRMD:   m_prmd = v[2:0];
            ECFG:   m_ecfg = v[12:0] & `CSR_LIE_MASK;
            ESTAT:  m_is = v[1:0];
            ERA:    m_era = v;
            BADV:   m_badv = v;
            EENTRY: m_eentry = {v[31:`CSR_ENTRY_LSB], {`CSR_ENTRY_LSB{1'b0}}};
            SAVE0:  m_save[0] = v;
            SAVE1:  m_save[1] = v;
            SAVE2:  m_save[2] = v;
            SAVE3:  m_save[3] = v;
            TCFG:   m_tcfg = v;
            TICLR:
            begin
                if (v[0])
                    m_timer_irq = 1'b0;
            end
            default: ;
        endcase
    endfunction

    // expected response of one request, and the state it leaves behind
    function automatic void predict(
        input  csr_op_e     op,
        input  logic [13:0] num,
        input  logic [31:0] wdata,
        input  logic [31:0] mask,
        input  logic [31:0] pc,
        input  ecode_e      ecode,
        input  logic [8:0]  esub,
        input  logic [31:0] badv,
        output logic [31:0] lo,
        output logic [31:0] hi,
        output logic        redir,
        output logic [31:0] tgt,
        output logic        excp,
        output logic        ertn
    );
        logic [31:0] old;
        logic [31:0] merged;
        if ((|(model_is() & m_ecfg)) && m_crmd[2])
        begin
            op    = OP_EXCP;
            ecode = INT;
            esub  = '0;
        end
        old = model_read(num);
        if (op == OP_CSRWR)
            mask = '1;
        merged = (wdata & mask) | (old & ~mask);
        lo = old;
        hi = old;
        if (op == OP_ERTN || op == OP_EXCP)
        begin
            lo = '0;
            hi = '0;
        end
        else if (num == TVAL)
        begin
            lo = m_tval_lo;
            hi = m_tval_hi;
        end
        redir = (op != OP_CSRRD);
        excp  = (op == OP_EXCP);
        ertn  = (op == OP_ERTN);
        tgt   = '0;
        case (op)
            OP_CSRWR, OP_CSRXCHG:
            begin
                tgt = pc + 32'd4;
                model_write(num, merged);
            end
            OP_ERTN:
            begin
                tgt = m_era;
                m_crmd[2:0] = m_prmd;
            end
            OP_EXCP:
            begin
                tgt = m_eentry;
                m_prmd = m_crmd[2:0];
                m_crmd[2:0] = 3'b000;
                m_era = pc;
                m_ecode = ecode;
                m_esub = esub;
                if (ecode == ADE && esub == ADEF)
                    m_badv = pc;
                else if (ecode inside {ALE, PIL, PIS, PIF, PME, PPI, TLBR})
                    m_badv = badv;
            end
            default: ;
        endcase
    endfunction

    task automatic note_error();
        errors++;
        test_errors++;
    endtask

    task automatic expect_equal(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        test_checks++;
        assert (act === exp)
        else
        begin
            $display("CHECK FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
            note_error();
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s: %s", test_name, why);
        $display("tests: %0d  checks: %0d  errors: %0d", tests_run, checks, errors + 1);
        $display("Done: errors found");
        $finish;
    endtask

    task automatic issue(
        input csr_op_e     op,
        input csr_num_e    num,
        input logic [31:0] wdata,
        input logic [31:0] mask,
        input ecode_e      ecode,
        input logic [8:0]  esub,
        input logic [31:0] badv
    );
        int          waited;
        logic [31:0] lo;
        logic [31:0] hi;
        logic [31:0] tgt;
        logic        redir;
        logic        excp;
        logic        ertn;
        @(negedge clk);
        req_valid    = 1'b1;
        req_op       = op;
        req_csr_num  = num;
        req_wdata    = wdata;
        req_mask     = mask;
        req_pc       = pc_ctr;
        req_ecode    = ecode;
        req_esubcode = esub;
        req_badv     = badv;
        waited = 0;
        while (!req_ready)
        begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT)
                abort_run("req_ready stayed low too long");
        end
        @(posedge clk);
        predict(op, num, wdata, mask, pc_ctr, ecode, esub, badv, lo, hi, redir, tgt, excp, ertn);
        exp_lo_q.push_back(lo);
        exp_hi_q.push_back(hi);
        exp_redir_q.push_back(redir);
        exp_pc_q.push_back(tgt);
        exp_excp_q.push_back(excp);
        exp_ertn_q.push_back(ertn);
        pc_ctr += 32'd4;
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic csr_read(input csr_num_e num);
        issue(OP_CSRRD, num, '0, '0, INT, '0, '0);
    endtask

    task automatic csr_write(input csr_num_e num, input logic [31:0] v);
        issue(OP_CSRWR, num, v, '1, INT, '0, '0);
    endtask

    task automatic csr_xchg(input csr_num_e num, input logic [31:0] v, input logic [31:0] mask);
        issue(OP_CSRXCHG, num, v, mask, INT, '0, '0);
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic finish_test();
        int waited;
        waited = 0;
        while (exp_lo_q.size() > 0)
        begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT)
                abort_run("responses never arrived");
        end
        tests_run++;
        $display("test %0d %s: %0d checks, %0d errors", tests_run, test_name, test_checks,
                 test_errors);
    endtask

    // outputs are registered, so the falling edge sees them settled
    always @(negedge clk)
    begin : compare
        logic [31:0] lo;
        logic [31:0] hi;
        logic [31:0] tgt;
        logic        redir;
        if (exp_lo_q.size() > 0)
        begin
            lo    = exp_lo_q.pop_front();
            hi    = exp_hi_q.pop_front();
            tgt   = exp_pc_q.pop_front();
            redir = exp_redir_q.pop_front();
            checks++;
            test_checks++;
            assert (rdata >= lo && rdata <= hi)
            else
            begin
                if (lo == hi)
                    $display("CHECK FAILED %s rdata: expected %h actual %h", test_name, lo, rdata);
                else
                    $display("CHECK FAILED %s rdata: expected %h..%h actual %h", test_name, lo, hi,
                             rdata);
                note_error();
            end
            expect_equal("redirect_valid", redir, redirect_valid);
            if (redir)
            begin
                expect_equal("redirect_pc", tgt, redirect_pc);
                // no new request while the fetch is redirected
                expect_equal("req_ready", 32'd0, {31'b0, req_ready});
            end
            expect_equal("excp_flush", exp_excp_q.pop_front(), excp_flush);
            expect_equal("ertn_flush", exp_ertn_q.pop_front(), ertn_flush);
        end
        else if (rstn)
        begin
            assert (!redirect_valid && !excp_flush && !ertn_flush)
            else
            begin
                $display("%s: redirect or flush pulse without an accepted request", test_name);
                note_error();
            end
        end
    end

    initial
    begin
        csr_num_e    nums [5];
        logic [31:0] irq_pc;
        clk          = 1'b0;
        rstn         = 1'b0;
        req_valid    = 1'b0;
        req_op       = OP_NONE;
        req_csr_num  = '0;
        req_wdata    = '0;
        req_mask     = '0;
        req_pc       = '0;
        req_ecode    = INT;
        req_esubcode = '0;
        req_badv     = '0;
        hw_int       = '0;
        seed         = 32'habdb_2ddb;
        pc_ctr       = 32'h1c00_0000;
        test_name    = "reset";
        checks       = 0;
        errors       = 0;
        tests_run    = 0;
        m_crmd       = `CSR_CRMD_RST;
        m_prmd       = '0;
        m_ecfg       = '0;
        m_is         = '0;
        m_ecode      = '0;
        m_esub       = '0;
        m_era        = '0;
        m_badv       = '0;
        m_eentry     = '0;
        m_tcfg       = '0;
        m_timer_irq  = 1'b0;
        m_tval_lo    = '0;
        m_tval_hi    = '1;
        for (int i = 0; i < 4; i++)
            m_save[i] = '0;
        nums = '{SAVE0, SAVE1, SAVE2, SAVE3, ERA};

        repeat (5) @(negedge clk);
        rstn = 1'b1;

        begin_test("write_read");
        for (int round = 0; round < 2; round++)
        begin
            for (int i = 0; i < 5; i++)
                csr_write(nums[i], lcg_next());
            for (int i = 0; i < 5; i++)
                csr_read(nums[i]);
        end
        finish_test();

        begin_test("masked_xchg");
        for (int i = 0; i < 8; i++)
        begin
            csr_xchg(nums[i % 4], lcg_next(), lcg_next());
            csr_read(nums[i % 4]);
        end
        finish_test();

        begin_test("exception");
        csr_write(EENTRY, lcg_next());
        // plv 3, ie on, da on
        csr_write(CRMD, 32'h0000_000f);
        issue(OP_EXCP, CRMD, '0, '0, ALE, '0, lcg_next());
        csr_read(CRMD);
        csr_read(PRMD);
        csr_read(ERA);
        csr_read(BADV);
        csr_read(ESTAT);
        finish_test();

        begin_test("return");
        issue(OP_ERTN, CRMD, '0, '0, INT, '0, '0);
        csr_read(CRMD);
        expect_equal("crmd_plv", {30'b0, m_crmd[1:0]}, {30'b0, crmd_plv});
        expect_equal("crmd_ie", {31'b0, m_crmd[2]}, {31'b0, crmd_ie});
        finish_test();

        begin_test("timer");
        // one-shot, initial value 0x100
        csr_write(TCFG, 32'h0000_0101);
        m_tval_lo = 32'd1;
        m_tval_hi = 32'h0000_00ff;
        repeat (4) @(negedge clk);
        csr_read(TVAL);
        csr_read(TCFG);
        repeat (400) @(negedge clk);
        m_timer_irq = 1'b1;
        csr_read(ESTAT);
        finish_test();

        begin_test("interrupt");
        csr_write(ECFG, 32'h0000_0001);
        csr_write(CRMD, 32'h0000_000c);
        csr_write(ESTAT, 32'h0000_0001);
        irq_pc = pc_ctr;
        csr_read(SAVE0);
        csr_read(ERA);
        // the era read is still on rdata here
        expect_equal("era", irq_pc, rdata);
        csr_write(ESTAT, 32'h0000_0000);
        csr_write(TICLR, 32'h0000_0001);
        csr_read(ESTAT);
        csr_read(CRMD);
        finish_test();

        $display("tests: %0d  checks: %0d  errors: %0d", tests_run, checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+rtl
rtl/csr_op_pkg.sv
rtl/csr_map_pkg.sv
rtl/csr_decode.sv
rtl/csr_stage.sv
rtl/csr_file.sv
rtl/csr_timer.sv
rtl/csr_top.sv
dv/csr_tb.sv
